// File: project.f
+incdir+rtl
rtl/frontend_pkg.sv
rtl/pc_gen.sv
rtl/fetch_stage.sv
rtl/inst_predecoder.sv
rtl/inst_queue.sv
rtl/frontend.sv
test/frontend_assertions.sv
test/tb_frontend.sv

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  frontend_pkg::pc_t          pc_i,
    input  logic                       fetch_en_i,
    input  logic                       flush_i,
    input  logic                       space_i,
    input  logic                       bus_busy_i,
    output logic                       fire_o,
    output frontend_pkg::bus_req_t     bus_req_o,
    input  frontend_pkg::bus_resp_t    bus_resp_i,
    output frontend_pkg::inst_word_t [1:0] word_o,
    output frontend_pkg::pc_t [1:0]    pc_pair_o,
    output logic [1:0]                 wr_num_o
);
    import frontend_pkg::*;

    fetch_state_e state;
    pc_t          req_pc;
    pc_t          base_pc;
    logic         stale;
    logic         resp_take;

    assign fire_o = (state == FETCH_IDLE) && fetch_en_i && space_i
                    && !bus_busy_i && !flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FETCH_IDLE;
            stale <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (fire_o) begin
                        state <= FETCH_WAIT;
                        stale <= 1'b0;
                    end
                end
                FETCH_WAIT: begin
                    if (bus_resp_i.valid) begin
                        state <= FETCH_IDLE;
                        stale <= 1'b0;
                    end else if (flush_i) begin
                        // response still has to be consumed
                        stale <= 1'b1;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // pc of the pair in flight
    always_ff @(posedge clk) begin
        if (fire_o) begin
            req_pc <= pc_i;
        end
    end

    assign base_pc         = {req_pc[31:3], 3'b000};
    assign bus_req_o.valid = (state == FETCH_WAIT);
    assign bus_req_o.addr  = base_pc;

    // a flush in the response cycle also kills the pair
    assign resp_take = (state == FETCH_WAIT) && bus_resp_i.valid && !stale && !flush_i;

    always_comb begin
        word_o[1]    = bus_resp_i.data[63:32];
        pc_pair_o[1] = {req_pc[31:3], 3'b100};
        if (req_pc[2]) begin
            // odd entry sends only the high word and moves it down to slot 0
            word_o[0]    = bus_resp_i.data[63:32];
            pc_pair_o[0] = {req_pc[31:3], 3'b100};
        end else begin
            word_o[0]    = bus_resp_i.data[31:0];
            pc_pair_o[0] = base_pc;
        end
        if (!resp_take) begin
            wr_num_o = 2'd0;
        end else if (req_pc[2]) begin
            wr_num_o = 2'd1;
        end else begin
            wr_num_o = 2'd2;
        end
    end

endmodule

// File: rtl/frontend.sv
`timescale 1ns/1ps

module frontend (
    input  logic                      clk,
    input  logic                      rst_n,
    input  frontend_pkg::redirect_t   redirect_i,
    input  logic                      wait_i,
    input  logic                      int_i,
    input  logic [1:0]                issue_num_i,
    input  logic                      backend_stall_i,
    output frontend_pkg::inst_t [1:0] inst_o,
    output logic [1:0]                inst_valid_o,
    output frontend_pkg::bus_req_t    bus_req_o,
    input  frontend_pkg::bus_resp_t   bus_resp_i,
    input  logic                      bus_busy_i
);
    import frontend_pkg::*;

    pc_t              pc;
    logic             fetch_en;
    logic             fire;
    logic             space;
    inst_word_t [1:0] word;
    pc_t [1:0]        pc_pair;
    logic [1:0]       wr_num;
    inst_t [1:0]      wr_data;

    pc_gen pc_gen_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect_i (redirect_i),
        .wait_i     (wait_i),
        .int_i      (int_i),
        .fire_i     (fire),
        .pc_o       (pc),
        .fetch_en_o (fetch_en)
    );

    fetch_stage fetch_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_i       (pc),
        .fetch_en_i (fetch_en),
        .flush_i    (redirect_i.flush),
        .space_i    (space),
        .bus_busy_i (bus_busy_i),
        .fire_o     (fire),
        .bus_req_o  (bus_req_o),
        .bus_resp_i (bus_resp_i),
        .word_o     (word),
        .pc_pair_o  (pc_pair),
        .wr_num_o   (wr_num)
    );

    // one predecoder per slot, packed straight into queue entries
    for (genvar i = 0; i < 2; i++) begin : g_slot
        inst_predecoder predecoder_i (
            .inst_i     (word[i]),
            .type_o     (wr_data[i].reg_type),
            .reg_info_o (wr_data[i].reg_info)
        );
        assign wr_data[i].pc   = pc_pair[i];
        assign wr_data[i].inst = word[i];
    end

    inst_queue inst_queue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush_i    (redirect_i.flush),
        .wr_num_i   (wr_num),
        .wr_data_i  (wr_data),
        .space_o    (space),
        .rd_valid_o (inst_valid_o),
        .rd_data_o  (inst_o),
        .rd_stall_i (backend_stall_i),
        .rd_num_i   (issue_num_i)
    );

endmodule

// File: rtl/frontend_defs.svh
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// first fetch address after reset
`define RESET_PC 32'h1c00_0000

// instruction queue entries, power of two
`define IQ_DEPTH 8

// major opcodes in inst[31:26]
`define OP_ALU3R  6'h00
`define OP_ALUI   6'h0a
`define OP_LOAD   6'h0e
`define OP_STORE  6'h0f
`define OP_BRANCH 6'h16
`define OP_BL     6'h15

// register usage classes
`define REG_TYPE_NONE 3'd0
`define REG_TYPE_RW   3'd1
`define REG_TYPE_RRW  3'd2
`define REG_TYPE_RR   3'd3
`define REG_TYPE_BL   3'd4

`endif

// File: rtl/frontend_pkg.sv
`include "frontend_defs.svh"

package frontend_pkg;

    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_word_t;
    typedef logic [4:0]  reg_idx_t;

    // how an instruction uses the register file
    typedef enum logic [2:0] {
        REG_NONE = `REG_TYPE_NONE,
        REG_RW   = `REG_TYPE_RW,
        REG_RRW  = `REG_TYPE_RRW,
        REG_RR   = `REG_TYPE_RR,
        REG_BL   = `REG_TYPE_BL
    } reg_type_e;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_e;

    typedef struct packed {
        reg_idx_t r_reg0;
        reg_idx_t r_reg1;
        reg_idx_t w_reg;
    } reg_info_t;

    // one queue entry
    typedef struct packed {
        pc_t        pc;
        inst_word_t inst;
        reg_type_e  reg_type;
        reg_info_t  reg_info;
    } inst_t;

    typedef struct packed {
        logic flush;
        pc_t  target;
    } redirect_t;

    typedef struct packed {
        logic valid;
        pc_t  addr;
    } bus_req_t;

    // low word at addr, high word at addr+4
    typedef struct packed {
        logic        valid;
        logic [63:0] data;
    } bus_resp_t;

endpackage

// File: rtl/inst_predecoder.sv
`timescale 1ns/1ps
`include "frontend_defs.svh"

module inst_predecoder (
    input  frontend_pkg::inst_word_t inst_i,
    output frontend_pkg::reg_type_e  type_o,
    output frontend_pkg::reg_info_t  reg_info_o
);
    import frontend_pkg::*;

    logic [5:0] opcode;
    reg_type_e  reg_type;

    assign opcode = inst_i[31:26];

    // opcode class
    always_comb begin
        case (opcode)
            `OP_ALU3R: begin
                reg_type = REG_RRW;
            end
            `OP_ALUI,
            `OP_LOAD: begin
                reg_type = REG_RW;
            end
            `OP_STORE,
            `OP_BRANCH: begin
                reg_type = REG_RR;
            end
            `OP_BL: begin
                reg_type = REG_BL;
            end
            default: begin
                reg_type = REG_NONE;
            end
        endcase
    end

    // register fields by class
    always_comb begin
        reg_info_o.r_reg0 = '0;
        reg_info_o.r_reg1 = '0;
        reg_info_o.w_reg  = '0;
        case (reg_type)
            REG_RRW: begin
                reg_info_o.r_reg0 = inst_i[14:10];
                reg_info_o.r_reg1 = inst_i[9:5];
                reg_info_o.w_reg  = inst_i[4:0];
            end
            REG_RW: begin
                reg_info_o.r_reg1 = inst_i[9:5];
                reg_info_o.w_reg  = inst_i[4:0];
            end
            REG_RR: begin
                // stores and branches read rd as a source
                reg_info_o.r_reg0 = inst_i[4:0];
                reg_info_o.r_reg1 = inst_i[9:5];
            end
            REG_BL: begin
                // link register
                reg_info_o.w_reg = 5'd1;
            end
            default: begin
                reg_info_o.w_reg = '0;
            end
        endcase
    end

    assign type_o = reg_type;

endmodule

// File: rtl/inst_queue.sv
`timescale 1ns/1ps
`include "frontend_defs.svh"

module inst_queue #(
    parameter int DEPTH = `IQ_DEPTH
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush_i,
    input  logic [1:0]               wr_num_i,
    input  frontend_pkg::inst_t [1:0] wr_data_i,
    output logic                     space_o,
    output logic [1:0]               rd_valid_o,
    output frontend_pkg::inst_t [1:0] rd_data_o,
    input  logic                     rd_stall_i,
    input  logic [1:0]               rd_num_i
);
    import frontend_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    inst_t            mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [1:0]       pop_num;

    // pop request clipped to 2 and to what is held
    always_comb begin
        if (rd_stall_i || count == '0) begin
            pop_num = 2'd0;
        end else if (count == CNT_W'(1)) begin
            pop_num = (rd_num_i != 2'd0) ? 2'd1 : 2'd0;
        end else begin
            pop_num = (rd_num_i > 2'd2) ? 2'd2 : rd_num_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(pop_num);
            wr_ptr <= wr_ptr + PTR_W'(wr_num_i);
            count  <= count + CNT_W'(wr_num_i) - CNT_W'(pop_num);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr_num_i != 2'd0) begin
            mem[wr_ptr] <= wr_data_i[0];
        end
        if (wr_num_i == 2'd2) begin
            mem[wr_ptr + PTR_W'(1)] <= wr_data_i[1];
        end
    end

    // room for a whole pair
    assign space_o = (count <= CNT_W'(DEPTH - 2));

    assign rd_valid_o[0] = (count >= CNT_W'(1));
    assign rd_valid_o[1] = (count >= CNT_W'(2));
    assign rd_data_o[0]  = mem[rd_ptr];
    assign rd_data_o[1]  = mem[rd_ptr + PTR_W'(1)];

endmodule

// File: rtl/pc_gen.sv
`timescale 1ns/1ps
`include "frontend_defs.svh"

module pc_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  frontend_pkg::redirect_t redirect_i,
    input  logic                   wait_i,
    input  logic                   int_i,
    input  logic                   fire_i,
    output frontend_pkg::pc_t      pc_o,
    output logic                   fetch_en_o
);
    import frontend_pkg::*;

    pc_t  pc;
    pc_t  pc_next_pair;
    logic idle_lock;

    // start of the following aligned pair
    assign pc_next_pair = {pc[31:3], 3'b000} + 32'd8;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (redirect_i.flush) begin
            // redirect wins over a fetch in the same cycle
            pc <= redirect_i.target;
        end else if (fire_i) begin
            pc <= pc_next_pair;
        end
    end

    // wait sets the idle lock and interrupt releases it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idle_lock <= 1'b0;
        end else if (wait_i && !int_i) begin
            idle_lock <= 1'b1;
        end else if (int_i) begin
            idle_lock <= 1'b0;
        end
    end

    assign pc_o       = pc;
    assign fetch_en_o = !idle_lock;

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_frontend \
    -Mdir obj_dir -o sim_frontend

output="$(./obj_dir/sim_frontend 2>&1)" || { echo "$output"; exit 1; }
echo "$output"

if grep -qF "*** TEST PASSED ***" <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: test/frontend_assertions.sv
`timescale 1ns/1ps

module frontend_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input frontend_pkg::bus_req_t  bus_req_i,
    input frontend_pkg::bus_resp_t bus_resp_i,
    input logic [1:0]              inst_valid_i,
    input logic                    wait_i,
    input logic                    int_i
);
    int unsigned fail_cnt = 0;
    logic        idle_model;

    // idle lock rebuilt from the wait and interrupt levels
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idle_model <= 1'b0;
        end else if (wait_i && !int_i) begin
            idle_model <= 1'b1;
        end else if (int_i) begin
            idle_model <= 1'b0;
        end
    end

    // request held with a fixed address until its response
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req_i.valid && !bus_resp_i.valid |=> bus_req_i.valid && $stable(bus_req_i.addr))
    else begin
        $error("bus request dropped or changed before its response");
        fail_cnt++;
    end

    valid_order: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid_i[1] |-> inst_valid_i[0])
    else begin
        $error("inst_valid_o[1] set without inst_valid_o[0]");
        fail_cnt++;
    end

    // the fire one cycle before the request needs the lock clear
    no_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_req_i.valid) |-> !$past(idle_model))
    else begin
        $error("bus request started under the idle lock");
        fail_cnt++;
    end

endmodule

// File: test/tb_frontend.sv
`timescale 1ns/1ps
`include "frontend_defs.svh"

module tb_frontend;
    import frontend_pkg::*;

    // about 300 pairs at up to 7 cycles each, with a wide margin
    localparam int  TIMEOUT_CYCLES = 20000;
    localparam int  MEM_WORDS      = 1024;
    localparam pc_t REDIRECT_PC    = 32'h1c00_0204;

    logic        clk           = 1'b0;
    logic        rst_n         = 1'b0;
    redirect_t   redirect      = '0;
    logic        wait_req      = 1'b0;
    logic        int_req       = 1'b0;
    logic [1:0]  issue_num     = 2'd2;
    logic        backend_stall = 1'b0;
    bus_resp_t   bus_resp      = '0;
    logic        bus_busy      = 1'b0;
    inst_t [1:0] inst;
    logic [1:0]  inst_valid;
    bus_req_t    bus_req;

    inst_word_t mem [MEM_WORDS];
    // defined opcodes plus one that decodes to REG_NONE
    logic [5:0] opcodes [7] = '{`OP_ALU3R, `OP_ALUI, `OP_LOAD, `OP_STORE,
                                `OP_BRANCH, `OP_BL, 6'h3f};

    // reference model state
    pc_t  exp_pc      = `RESET_PC;
    pc_t  fetch_pc    = `RESET_PC;
    pc_t  req_pc      = '0;
    int   model_count = 0;
    logic model_stale = 1'b0;
    logic req_prev    = 1'b0;
    int   popped      = 0;
    int   cycles      = 0;
    logic idle_expect = 1'b0;
    logic serving     = 1'b0;
    int   delay       = 0;

    frontend dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect_i      (redirect),
        .wait_i          (wait_req),
        .int_i           (int_req),
        .issue_num_i     (issue_num),
        .backend_stall_i (backend_stall),
        .inst_o          (inst),
        .inst_valid_o    (inst_valid),
        .bus_req_o       (bus_req),
        .bus_resp_i      (bus_resp),
        .bus_busy_i      (bus_busy)
    );

    bind frontend frontend_assertions asrt_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_req_i    (bus_req_o),
        .bus_resp_i   (bus_resp_i),
        .inst_valid_i (inst_valid_o),
        .wait_i       (wait_i),
        .int_i        (int_i)
    );

    always #20 clk = ~clk;

    function automatic inst_word_t mem_word(input pc_t addr);
        return mem[addr[11:2]];
    endfunction

    // expected queue entry for the word at pc
    function automatic inst_t expected_entry(input pc_t pc);
        inst_t e;
        e.pc       = pc;
        e.inst     = mem_word(pc);
        e.reg_type = REG_NONE;
        e.reg_info = '0;
        case (e.inst[31:26])
            `OP_ALU3R: begin
                e.reg_type = REG_RRW;
                e.reg_info = {e.inst[14:10], e.inst[9:5], e.inst[4:0]};
            end
            `OP_ALUI, `OP_LOAD: begin
                e.reg_type = REG_RW;
                e.reg_info = {5'd0, e.inst[9:5], e.inst[4:0]};
            end
            `OP_STORE, `OP_BRANCH: begin
                e.reg_type = REG_RR;
                e.reg_info = {e.inst[4:0], e.inst[9:5], 5'd0};
            end
            `OP_BL: begin
                e.reg_type = REG_BL;
                e.reg_info = {10'd0, 5'd1};
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_inst(input inst_t got, input inst_t exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_valid(input logic [1:0] got, input logic [1:0] exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input pc_t got, input pc_t exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s got %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    // memory answers after 1 to 4 cycles and is busy now and then between requests
    always @(posedge clk) begin
        if (!rst_n) begin
            bus_resp <= '0;
            bus_busy <= 1'b0;
            serving  = 1'b0;
        end else if (bus_resp.valid) begin
            bus_resp <= '0;
            serving  = 1'b0;
        end else if (bus_req.valid) begin
            if (!serving) begin
                serving = 1'b1;
                delay   = $urandom_range(3, 0);
            end
            if (delay == 0) begin
                bus_resp <= {1'b1, mem_word(bus_req.addr + 32'd4), mem_word(bus_req.addr)};
            end else begin
                delay--;
            end
            bus_busy <= 1'b0;
        end else begin
            bus_busy <= ($urandom_range(4, 0) == 0);
        end
    end

    // reference model and output checks at mid-cycle
    always @(negedge clk) begin
        int wr;
        int pops;
        wr   = 0;
        pops = 0;
        if (rst_n) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                abort_run("timeout: the tests did not finish within the cycle limit");
            end
            if (dut_i.asrt_i.fail_cnt != 0) begin
                abort_run("a protocol assertion failed");
            end
            check_valid(inst_valid, {model_count >= 2, model_count >= 1}, "inst_valid_o");
            if (bus_req.valid && !req_prev) begin
                if (idle_expect) begin
                    abort_run("a new bus request started while the frontend was idle");
                end
                check_addr(bus_req.addr, {fetch_pc[31:3], 3'b000}, "bus_req_o.addr");
                req_pc   = fetch_pc;
                fetch_pc = {fetch_pc[31:3], 3'b000} + 32'd8;
            end
            req_prev = bus_req.valid;
            if (redirect.flush) begin
                // pair in flight goes stale unless answered in this cycle
                model_stale = bus_req.valid && !bus_resp.valid;
                fetch_pc    = redirect.target;
                exp_pc      = redirect.target;
                model_count = 0;
            end else begin
                if (bus_resp.valid && bus_req.valid) begin
                    if (model_stale) begin
                        model_stale = 1'b0;
                    end else begin
                        wr = req_pc[2] ? 1 : 2;
                    end
                end
                if (!backend_stall) begin
                    for (int k = 0; k < 2; k++) begin
                        if (k < int'(issue_num) && k < model_count) begin
                            check_inst(inst[1'(k)], expected_entry(exp_pc), "inst_o");
                            exp_pc = exp_pc + 32'd4;
                            pops++;
                        end
                    end
                end
                popped      += pops;
                model_count += wr - pops;
            end
        end
    end

    task automatic wait_popped(input int n);
        int goal;
        goal = popped + n;
        while (popped < goal) @(posedge clk);
    endtask

    task automatic test_reset();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_valid(inst_valid, 2'b00, "inst_valid_o");
        check_valid({1'b0, bus_req.valid}, 2'b00, "bus_req_o.valid");
        do begin
            @(negedge clk);
        end while (!bus_req.valid);
        check_addr(bus_req.addr, `RESET_PC, "bus_req_o.addr");
    endtask

    task automatic test_stream();
        wait_popped(40);
    endtask

    // redirect while a pair is still outstanding
    task automatic test_redirect();
        // memory still has at least one cycle to go before it answers
        do begin
            @(negedge clk);
        end while (!(bus_req.valid && serving && delay > 0 && !bus_resp.valid));
        @(posedge clk);
        redirect <= {1'b1, REDIRECT_PC};
        @(posedge clk);
        redirect <= '0;
        wait_popped(24);
    endtask

    task automatic test_backpressure();
        repeat (200) begin
            @(posedge clk);
            backend_stall <= 1'($urandom_range(1, 0));
            issue_num     <= 2'($urandom_range(2, 0));
        end
        @(posedge clk);
        backend_stall <= 1'b0;
        issue_num     <= 2'd2;
        wait_popped(10);
    endtask

    task automatic test_idle();
        @(posedge clk);
        wait_req <= 1'b1;
        @(posedge clk);
        wait_req <= 1'b0;
        // a fire from the cycle before the lock may still show up
        @(posedge clk);
        idle_expect = 1'b1;
        while (model_count != 0 || bus_req.valid) @(posedge clk);
        repeat (20) @(posedge clk);
        @(negedge clk);
        check_valid(inst_valid, 2'b00, "inst_valid_o");
        @(posedge clk);
        int_req     <= 1'b1;
        idle_expect = 1'b0;
        @(posedge clk);
        int_req <= 1'b0;
        wait_popped(20);
    endtask

    initial begin
        void'($urandom(32'hae00_3e18));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[10'(i)] = {opcodes[3'($urandom_range(6, 0))], 26'($urandom)};
        end
        test_reset();
        test_stream();
        test_redirect();
        test_backpressure();
        test_idle();
        if (dut_i.asrt_i.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("protocol assertions failed during the run");
        end
    end

endmodule
